/* fetch_top.f */
hw/fetch_pkg.sv
hw/imem_load_if.sv
hw/pc_unit.sv
hw/instr_mem.sv
hw/prog_loader.sv
hw/fetch_stage.sv
hw/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - hw/fetch_pkg.sv
  - hw/imem_load_if.sv
  - hw/pc_unit.sv
  - hw/instr_mem.sv
  - hw/prog_loader.sv
  - hw/fetch_stage.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - tests/fetch_checker.sv
      - tests/fetch_tb.sv

/* tests/fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

	// Program size and where the halt word sits
	localparam int prog_len = 64;
	localparam int halt_index = 63;

	logic clk;
	logic reset;
	fetch_pkg::pc_src_t pc_src;
	logic [fetch_pkg::word_width-1:0] pc_jump, pc_branch, pc_register;
	logic advance;
	logic load_start, load_valid, load_end;
	logic [fetch_pkg::word_width-1:0] load_data;
	logic [fetch_pkg::word_width-1:0] instruction, pc, pc_plus1;
	logic halted, loading;

	int check_errors;
	int tb_errors;
	integer seed;
	logic [fetch_pkg::word_width-1:0] prog [prog_len];

	fetch_top dut_i (
		.clk         (clk),
		.reset       (reset),
		.pc_src      (pc_src),
		.pc_jump     (pc_jump),
		.pc_branch   (pc_branch),
		.pc_register (pc_register),
		.advance     (advance),
		.load_start  (load_start),
		.load_valid  (load_valid),
		.load_data   (load_data),
		.load_end    (load_end),
		.instruction (instruction),
		.pc          (pc),
		.pc_plus1    (pc_plus1),
		.halted      (halted),
		.loading     (loading)
	);

	fetch_checker checker_i (
		.clk (clk), .reset (reset), .pc_src (pc_src), .pc_jump (pc_jump),
		.pc_branch (pc_branch), .pc_register (pc_register), .advance (advance),
		.load_start (load_start), .load_valid (load_valid), .load_data (load_data),
		.load_end (load_end), .instruction (instruction), .pc (pc),
		.pc_plus1 (pc_plus1), .halted (halted), .loading (loading),
		.error_count (check_errors)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	// Target inside the low half of the program
	function automatic logic [fetch_pkg::word_width-1:0] random_target();
		return {$random(seed)} % 32;
	endfunction

	task automatic wait_loading(input logic level);
		int cycles;
		for (cycles = 0; cycles < 16 && loading !== level; cycles++) begin
			tick();
		end
		if (loading !== level) begin
			$display("Timed out waiting for loading to go %0d", level);
			tb_errors++;
		end
	endtask

	task automatic load_program();
		int i;
		load_start = 1'b1;
		tick();
		load_start = 1'b0;
		wait_loading(1'b1);
		for (i = 0; i < prog_len; i++) begin
			load_valid = 1'b1;
			load_data  = prog[i];
			tick();
		end
		// Gap lets the last write retire before the download closes
		load_valid = 1'b0;
		tick();
		load_end = 1'b1;
		tick();
		load_end = 1'b0;
		wait_loading(1'b0);
	endtask

	task automatic pick_source();
		case ({$random(seed)} % 10)
			0:       pc_src = fetch_pkg::pc_branch;
			1:       pc_src = fetch_pkg::pc_jump;
			2:       pc_src = fetch_pkg::pc_register;
			default: pc_src = fetch_pkg::pc_seq;
		endcase
	endtask

	task automatic run_redirect(input fetch_pkg::pc_src_t src);
		pc_branch   = random_target();
		pc_jump     = random_target();
		pc_register = random_target();
		pc_src  = src;
		advance = 1'b1;
		tick();
		pc_src = fetch_pkg::pc_seq;
		repeat (3) tick();
	endtask

	// Random stalls, redirects and targets, kept away from the halt word
	task automatic run_random(input int cycles);
		int i;
		for (i = 0; i < cycles; i++) begin
			advance     = ({$random(seed)} % 4) != 0;
			pc_branch   = random_target();
			pc_jump     = random_target();
			pc_register = random_target();
			pick_source();
			if (pc >= 40) begin
				pc_src = fetch_pkg::pc_jump;
			end
			tick();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int i;
		int cycles;
		seed        = 96;
		tb_errors   = 0;
		reset       = 1'b1;
		pc_src      = fetch_pkg::pc_seq;
		pc_jump     = '0;
		pc_branch   = '0;
		pc_register = '0;
		advance     = 1'b0;
		load_start  = 1'b0;
		load_valid  = 1'b0;
		load_data   = '0;
		load_end    = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		tick();

		// Random program, no stray halt words, halt at the end
		for (i = 0; i < prog_len; i++) begin
			prog[i] = $random(seed);
			if (prog[i] == fetch_pkg::halt_word) begin
				prog[i] = '0;
			end
		end
		prog[halt_index] = fetch_pkg::halt_word;
		load_program();

		// Straight line fetch from word zero
		advance = 1'b1;
		pc_src  = fetch_pkg::pc_seq;
		repeat (20) tick();

		run_redirect(fetch_pkg::pc_branch);
		run_redirect(fetch_pkg::pc_jump);
		run_redirect(fetch_pkg::pc_register);

		// Stall gaps of random length
		for (i = 0; i < 6; i++) begin
			advance = 1'b0;
			repeat (1 + {$random(seed)} % 4) tick();
			advance = 1'b1;
			tick();
		end

		run_random(200);

		// Run into the halt word
		advance = 1'b1;
		pc_src  = fetch_pkg::pc_jump;
		pc_jump = halt_index - 3;
		tick();
		pc_src = fetch_pkg::pc_seq;
		for (cycles = 0; cycles < 20 && halted !== 1'b1; cycles++) begin
			tick();
		end
		if (halted !== 1'b1) begin
			$display("Timed out waiting for halted to rise");
			tb_errors++;
		end
		repeat (6) tick();

		// Reset clears the halt
		advance = 1'b0;
		reset   = 1'b1;
		repeat (3) tick();
		reset = 1'b0;
		repeat (3) tick();

		$display("Errors: checker %0d, testbench %0d", check_errors, tb_errors);
		if (check_errors == 0 && tb_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/fetch_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_checker (
	input  wire logic                             clk,
	input  wire logic                             reset,
	input  wire fetch_pkg::pc_src_t               pc_src,
	input  wire logic [fetch_pkg::word_width-1:0] pc_jump,
	input  wire logic [fetch_pkg::word_width-1:0] pc_branch,
	input  wire logic [fetch_pkg::word_width-1:0] pc_register,
	input  wire logic                             advance,
	input  wire logic                             load_start,
	input  wire logic                             load_valid,
	input  wire logic [fetch_pkg::word_width-1:0] load_data,
	input  wire logic                             load_end,
	input  wire logic [fetch_pkg::word_width-1:0] instruction,
	input  wire logic [fetch_pkg::word_width-1:0] pc,
	input  wire logic [fetch_pkg::word_width-1:0] pc_plus1,
	input  wire logic                             halted,
	input  wire logic                             loading,
	output int                                    error_count
);

	// Shadow of the instruction memory, built from the download traffic
	logic [fetch_pkg::word_width-1:0] ref_mem [fetch_pkg::imem_depth];
	logic [fetch_pkg::imem_addr_width-1:0] load_index;
	fetch_pkg::loader_state_t exp_state;

	// Inputs and outputs seen at the previous falling edge
	logic have_prev;
	logic prev_advance;
	fetch_pkg::pc_src_t prev_src;
	logic [fetch_pkg::word_width-1:0] prev_pc, prev_instr, prev_plus1;
	logic [fetch_pkg::word_width-1:0] prev_jump, prev_branch, prev_register;

	int errors = 0;

	assign error_count = errors;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// One rising edge of the fetch stage
	function automatic void predict(
		input  logic [fetch_pkg::word_width-1:0] pc_q,
		input  logic [fetch_pkg::word_width-1:0] instr_q,
		input  logic [fetch_pkg::word_width-1:0] plus1_q,
		input  logic [fetch_pkg::word_width-1:0] mem_word,
		input  logic [fetch_pkg::word_width-1:0] jump_t,
		input  logic [fetch_pkg::word_width-1:0] branch_t,
		input  logic [fetch_pkg::word_width-1:0] register_t,
		input  fetch_pkg::pc_src_t               src,
		input  logic                             adv,
		output logic [fetch_pkg::word_width-1:0] pc_d,
		output logic [fetch_pkg::word_width-1:0] instr_d,
		output logic [fetch_pkg::word_width-1:0] plus1_d
	);
		logic stopped;
		logic redirect;
		stopped  = (instr_q == fetch_pkg::halt_word);
		redirect = (src == fetch_pkg::pc_branch) || (src == fetch_pkg::pc_jump) ||
			(src == fetch_pkg::pc_register);
		pc_d    = pc_q;
		instr_d = instr_q;
		plus1_d = plus1_q;
		// Halt word freezes both the PC and the fetched word
		if (adv && !stopped) begin
			instr_d = redirect ? fetch_pkg::nop_word : mem_word;
			case (src)
				fetch_pkg::pc_branch:   pc_d = branch_t;
				fetch_pkg::pc_jump:     pc_d = jump_t;
				fetch_pkg::pc_register: pc_d = register_t;
				default:                pc_d = pc_q + 1;
			endcase
		end
		// Flush reaches PC+1 even in a stall
		if (redirect) begin
			plus1_d = '0;
		end else if (adv) begin
			plus1_d = pc_q + 1;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare at the falling edge, where everything is settled
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic [fetch_pkg::word_width-1:0] exp_pc, exp_instr, exp_plus1;
		if (reset) begin
			check_value("instruction", '0, instruction);
			check_value("pc", '0, pc);
			check_value("pc_plus1", '0, pc_plus1);
			check_value("halted", '0, {31'b0, halted});
			check_value("loading", '0, {31'b0, loading});
			exp_state = fetch_pkg::load_idle;
			have_prev = 1'b0;
		end else begin
			if (have_prev) begin
				predict(prev_pc, prev_instr, prev_plus1,
					ref_mem[prev_pc[fetch_pkg::imem_addr_width-1:0]],
					prev_jump, prev_branch, prev_register, prev_src, prev_advance,
					exp_pc, exp_instr, exp_plus1);
				check_value("pc", exp_pc, pc);
				check_value("instruction", exp_instr, instruction);
				check_value("pc_plus1", exp_plus1, pc_plus1);
				// Halt flag trails the instruction register by one edge
				check_value("halted", {31'b0, prev_instr == fetch_pkg::halt_word},
					{31'b0, halted});
				check_value("loading", {31'b0, exp_state == fetch_pkg::load_active},
					{31'b0, loading});
			end
			// Download effects of the coming edge
			if (exp_state == fetch_pkg::load_idle) begin
				if (load_start) begin
					exp_state  = fetch_pkg::load_active;
					load_index = '0;
				end
			end else begin
				if (load_valid) begin
					ref_mem[load_index] = load_data;
					load_index = load_index + 1'b1;
				end
				if (load_end) begin
					exp_state = fetch_pkg::load_idle;
				end
			end
			have_prev     = 1'b1;
			prev_advance  = advance;
			prev_src      = pc_src;
			prev_pc       = pc;
			prev_instr    = instruction;
			prev_plus1    = pc_plus1;
			prev_jump     = pc_jump;
			prev_branch   = pc_branch;
			prev_register = pc_register;
		end
	end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
	input  wire logic                             clk,
	input  wire logic                             reset,

	// Next-PC control from decode and execute
	input  wire fetch_pkg::pc_src_t               pc_src,
	input  wire logic [fetch_pkg::word_width-1:0] pc_jump,
	input  wire logic [fetch_pkg::word_width-1:0] pc_branch,
	input  wire logic [fetch_pkg::word_width-1:0] pc_register,
	input  wire logic                             advance,

	// Debug program download
	input  wire logic                             load_start,
	input  wire logic                             load_valid,
	input  wire logic [fetch_pkg::word_width-1:0] load_data,
	input  wire logic                             load_end,

	// Towards decode
	output logic      [fetch_pkg::word_width-1:0] instruction,
	output logic      [fetch_pkg::word_width-1:0] pc,
	output logic      [fetch_pkg::word_width-1:0] pc_plus1,
	output logic                                  halted,
	output logic                                  loading
);

	// Loader to memory bundle
	imem_load_if load_bus ();

	prog_loader prog_loader_i (
		.clk    (clk),
		.reset  (reset),
		.start  (load_start),
		.valid  (load_valid),
		.data   (load_data),
		.finish (load_end),
		.load   (load_bus.loader)
	);

	fetch_stage fetch_stage_i (
		.clk             (clk),
		.reset           (reset),
		.src             (pc_src),
		.jump_target     (pc_jump),
		.branch_target   (pc_branch),
		.register_target (pc_register),
		.advance         (advance),
		.load            (load_bus.memory),
		.instruction     (instruction),
		.pc              (pc),
		.pc_plus1        (pc_plus1),
		.halted          (halted)
	);

	// Download status for the debug link
	assign loading = load_bus.loading;

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
	input  wire logic                             clk,
	input  wire logic                             reset,
	input  wire fetch_pkg::pc_src_t               src,
	input  wire logic [fetch_pkg::word_width-1:0] jump_target,
	input  wire logic [fetch_pkg::word_width-1:0] branch_target,
	input  wire logic [fetch_pkg::word_width-1:0] register_target,
	input  wire logic                             advance,
	imem_load_if.memory                           load,
	output logic      [fetch_pkg::word_width-1:0] instruction,
	output logic      [fetch_pkg::word_width-1:0] pc,
	output logic      [fetch_pkg::word_width-1:0] pc_plus1,
	output logic                                  halted
);

	// Redirect from branch, jump or register source
	logic flush;

	// Halt word sitting in the instruction register
	logic is_halt;

	// Read strobe into the memory output register
	logic mem_enable;

	// Increment shared with the PC unit
	logic [fetch_pkg::word_width-1:0] pc_next_seq;

	// Memory index, PC or loader override
	logic [fetch_pkg::imem_addr_width-1:0] mem_addr;

	assign flush = src[0];

	// Halt freezes the fetched word as well as the PC
	assign mem_enable = advance && !is_halt;

	// Downloader owns the address while loading
	assign mem_addr = load.loading ? load.wr_addr : pc[fetch_pkg::imem_addr_width-1:0];

	////////////////////////////////////////////////////////////////////////////
	// PC and memory
	////////////////////////////////////////////////////////////////////////////

	pc_unit pc_unit_i (
		.clk             (clk),
		.reset           (reset),
		.advance         (advance),
		.hold            (is_halt),
		.src             (src),
		.jump_target     (jump_target),
		.branch_target   (branch_target),
		.register_target (register_target),
		.pc              (pc),
		.pc_next_seq     (pc_next_seq)
	);

	instr_mem instr_mem_i (
		.clk     (clk),
		.reset   (reset),
		.enable  (mem_enable),
		.flush   (flush),
		.rd_addr (mem_addr),
		.load    (load),
		.rd_data (instruction),
		.is_halt (is_halt)
	);

	////////////////////////////////////////////////////////////////////////////
	// Side outputs
	////////////////////////////////////////////////////////////////////////////

	// PC+1 for the branch unit
	// Zeroed on a redirect even while stalled
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc_plus1 <= '0;
		end else if (flush) begin
			pc_plus1 <= '0;
		end else if (advance) begin
			pc_plus1 <= pc_next_seq;
		end
	end

	// Halt flag trails the instruction by one cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			halted <= 1'b0;
		end else begin
			halted <= is_halt;
		end
	end

	// Pipeline must be stopped for a program download
	a_no_advance_when_loading : assert property (
		@(posedge clk) disable iff (reset)
		!(advance && load.loading)
	) else $error("advance raised during program load");

endmodule

`default_nettype wire

/* hw/prog_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module prog_loader (
	input  wire logic                             clk,
	input  wire logic                             reset,
	input  wire logic                             start,
	input  wire logic                             valid,
	input  wire logic [fetch_pkg::word_width-1:0] data,
	input  wire logic                             finish,
	imem_load_if.loader                           load
);

	// Download FSM
	fetch_pkg::loader_state_t state;

	// Next free word in the memory
	logic [fetch_pkg::imem_addr_width-1:0] wr_index;

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	// Start opens a download at word zero, finish closes it
	// Each accepted word advances the index
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= fetch_pkg::load_idle;
			wr_index <= '0;
			load.wr_en <= 1'b0;
		end else begin
			load.wr_en <= 1'b0;
			case (state)
				fetch_pkg::load_idle: begin
					if (start) begin
						state    <= fetch_pkg::load_active;
						wr_index <= '0;
					end
				end
				fetch_pkg::load_active: begin
					if (valid) begin
						load.wr_en <= 1'b1;
						wr_index   <= wr_index + 1'b1;
					end
					if (finish) begin
						state <= fetch_pkg::load_idle;
					end
				end
				default: begin
					state <= fetch_pkg::load_idle;
				end
			endcase
		end
	end

	// Level seen by the fetch stage for the address override
	assign load.loading = (state == fetch_pkg::load_active);

	////////////////////////////////////////////////////////////////////////////
	// Write payload
	////////////////////////////////////////////////////////////////////////////

	// Captured alongside the strobe, index taken before it increments
	always_ff @(posedge clk) begin
		if (valid) begin
			load.wr_addr <= wr_index;
			load.wr_data <= data;
		end
	end

	// Words arriving outside a download would be dropped
	a_valid_in_active : assert property (
		@(posedge clk) disable iff (reset)
		valid |-> (state == fetch_pkg::load_active)
	) else $error("load_valid seen while loader idle");

endmodule

`default_nettype wire

/* hw/instr_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_mem (
	input  wire logic                                  clk,
	input  wire logic                                  reset,
	input  wire logic                                  enable,
	input  wire logic                                  flush,
	input  wire logic [fetch_pkg::imem_addr_width-1:0] rd_addr,
	imem_load_if.memory                                load,
	output logic      [fetch_pkg::word_width-1:0]      rd_data,
	output logic                                       is_halt
);

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// Program words, filled only by the debug loader
	logic [fetch_pkg::word_width-1:0] mem [fetch_pkg::imem_depth];

	// Write port
	// Loader supplies index and word together with the strobe
	always_ff @(posedge clk) begin
		if (load.wr_en) begin
			mem[load.wr_addr] <= load.wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port with output register
	////////////////////////////////////////////////////////////////////////////

	// One cycle of read latency
	// Flush replaces the fetched word by a bubble
	// Output holds while the stage is stalled
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_data <= '0;
		end else if (enable) begin
			if (flush) begin
				rd_data <= fetch_pkg::nop_word;
			end else begin
				rd_data <= mem[rd_addr];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Halt detection
	////////////////////////////////////////////////////////////////////////////

	// Looks at the registered word, so it lines up with the instruction output
	assign is_halt = (rd_data == fetch_pkg::halt_word);

	// Loader writes only while fetch is stopped
	a_no_write_during_fetch : assert property (
		@(posedge clk) disable iff (reset)
		!(load.wr_en && enable)
	) else $error("memory write collided with an enabled fetch read");

	// Strobes outside a download would corrupt the running program
	a_write_inside_load : assert property (
		@(posedge clk) disable iff (reset)
		load.wr_en |-> load.loading
	) else $error("memory write strobe seen without loading");

endmodule

`default_nettype wire

/* hw/pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire logic                              advance,
	input  wire logic                              hold,
	input  wire fetch_pkg::pc_src_t                src,
	input  wire logic [fetch_pkg::word_width-1:0]  jump_target,
	input  wire logic [fetch_pkg::word_width-1:0]  branch_target,
	input  wire logic [fetch_pkg::word_width-1:0]  register_target,
	output logic      [fetch_pkg::word_width-1:0]  pc,
	output logic      [fetch_pkg::word_width-1:0]  pc_next_seq
);

	// Selected next program counter
	logic [fetch_pkg::word_width-1:0] pc_next;

	////////////////////////////////////////////////////////////////////////////
	// Increment and next-PC select
	////////////////////////////////////////////////////////////////////////////

	// Word addressed, so one step is one instruction
	assign pc_next_seq = pc + 1'b1;

	always_comb begin
		case (src)
			// Taken branch from execute
			fetch_pkg::pc_branch: begin
				pc_next = branch_target;
			end
			// Absolute jump from decode
			fetch_pkg::pc_jump: begin
				pc_next = jump_target;
			end
			// Jump register
			fetch_pkg::pc_register: begin
				pc_next = register_target;
			end
			// Sequential flow, also any unused code
			default: begin
				pc_next = pc_next_seq;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Program counter register
	////////////////////////////////////////////////////////////////////////////

	// Moves only when the pipeline advances
	// A halt word in the instruction register pins the PC
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (advance && !hold) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

/* hw/imem_load_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Debug write path into the instruction memory
interface imem_load_if;

	// High for the whole program download
	logic loading;

	// One-cycle write strobe
	logic wr_en;

	// Target word index and the word itself
	logic [fetch_pkg::imem_addr_width-1:0] wr_addr;
	logic [fetch_pkg::word_width-1:0]      wr_data;

	// Loader side drives everything
	modport loader (
		output loading,
		output wr_en,
		output wr_addr,
		output wr_data
	);

	// Memory side, also seen by the fetch stage for the address override
	modport memory (
		input loading,
		input wr_en,
		input wr_addr,
		input wr_data
	);

endinterface

`default_nettype wire

/* hw/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath and memory geometry
	////////////////////////////////////////////////////////////////////////////

	// Instruction and address width
	localparam int word_width = 32;

	// Instruction memory size in words
	localparam int imem_depth = 2048;

	// Word index bits into the memory
	localparam int imem_addr_width = $clog2(imem_depth);

	////////////////////////////////////////////////////////////////////////////
	// Special instruction words
	////////////////////////////////////////////////////////////////////////////

	// All ones stops fetch until reset
	localparam logic [word_width-1:0] halt_word = '1;

	// Bubble inserted when a redirect flushes the fetched word
	localparam logic [word_width-1:0] nop_word = '0;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// Next-PC source from decode and execute
	// Bit 0 set marks a redirect, which flushes the fetched word
	typedef enum logic [2:0] {
		pc_seq      = 3'b000,
		pc_branch   = 3'b001,
		pc_jump     = 3'b011,
		pc_register = 3'b101
	} pc_src_t;

	// Debug loader FSM
	typedef enum logic {
		load_idle,
		load_active
	} loader_state_t;

endpackage

`default_nettype wire
